// ==== source/bch_pkg.sv ====
package bch_pkg;

	// code geometry
	localparam int FIELD_M = 4;
	localparam int CODE_N = 15;
	localparam int CODE_K = 5;
	localparam int CODE_T = 3;

	// x^4 + x + 1
	localparam logic [FIELD_M:0] PRIM_POLY = 5'b10011;

	// serial discrepancy takes FIELD_M cycles, update takes two
	localparam int BM_STEP_CYCLES = FIELD_M + 2;

	// syndrome, solver, chien load, err register, output register
	localparam int DECODE_LATENCY = CODE_N + CODE_T * BM_STEP_CYCLES + 4;

	typedef logic [FIELD_M-1:0] gf_elem_t;

	typedef struct packed {
		gf_elem_t s1;
		gf_elem_t s2;
		gf_elem_t s3;
		gf_elem_t s4;
		gf_elem_t s5;
		gf_elem_t s6;
	} syn_vec_t;

	typedef struct packed {
		gf_elem_t c0;
		gf_elem_t c1;
		gf_elem_t c2;
		gf_elem_t c3;
	} sigma_t;

	// alpha^0 .. alpha^5 in polynomial basis
	localparam gf_elem_t ALPHA_POW [0:5] = '{
		4'b0001,
		4'b0010,
		4'b0100,
		4'b1000,
		4'b0011,
		4'b0110
	};

	function automatic gf_elem_t gf_mul(gf_elem_t a, gf_elem_t b);
		gf_elem_t prod;
		gf_elem_t x;
		prod = '0;
		x = a;
		for (int i = 0; i < FIELD_M; i++) begin
			if (b[i])
				prod = prod ^ x;
			// multiply x by alpha, reduce on overflow
			x = x[FIELD_M-1] ? ((x << 1) ^ PRIM_POLY[FIELD_M-1:0]) : (x << 1);
		end
		return prod;
	endfunction

	function automatic gf_elem_t gf_square(gf_elem_t a);
		return gf_mul(a, a);
	endfunction

endpackage

// ==== source/bch_syndrome.sv ====
`timescale 1ns/10ps

module bch_syndrome
	import bch_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     start,
	input  logic     data_in,
	output logic     syn_done,
	output syn_vec_t syn
);

	gf_elem_t acc1;
	gf_elem_t acc3;
	gf_elem_t acc5;
	gf_elem_t nxt1;
	gf_elem_t nxt3;
	gf_elem_t nxt5;
	gf_elem_t in_bit;
	logic [3:0] cnt;
	logic busy;
	logic last;

	assign in_bit = {{(FIELD_M-1){1'b0}}, data_in};
	assign last = busy && (cnt == 4'(CODE_N - 1));

	// horner step, start restarts from zero
	always_comb begin
		nxt1 = gf_mul(start ? '0 : acc1, ALPHA_POW[1]) ^ in_bit;
		nxt3 = gf_mul(start ? '0 : acc3, ALPHA_POW[3]) ^ in_bit;
		nxt5 = gf_mul(start ? '0 : acc5, ALPHA_POW[5]) ^ in_bit;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cnt <= '0;
			syn_done <= 1'b0;
		end else begin
			syn_done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				cnt <= 4'd1;
			end else if (busy) begin
				cnt <= cnt + 4'd1;
				if (last) begin
					busy <= 1'b0;
					syn_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start || busy) begin
			acc1 <= nxt1;
			acc3 <= nxt3;
			acc5 <= nxt5;
		end
		// even syndromes are squares in a binary code
		if (last && !start) begin
			syn.s1 <= nxt1;
			syn.s2 <= gf_square(nxt1);
			syn.s3 <= nxt3;
			syn.s4 <= gf_square(gf_square(nxt1));
			syn.s5 <= nxt5;
			syn.s6 <= gf_square(nxt3);
		end
	end

endmodule

// ==== source/bch_berlekamp.sv ====
`timescale 1ns/10ps

module bch_berlekamp
	import bch_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     syn_done,
	input  syn_vec_t syn,
	output logic     sigma_done,
	output sigma_t   sigma
);

	syn_vec_t syn_q;
	syn_vec_t cur_syn;
	gf_elem_t sig [0:CODE_T];
	gf_elem_t sig_nxt [0:CODE_T];
	gf_elem_t bb [0:CODE_T];
	gf_elem_t cur_sig [0:CODE_T];
	gf_elem_t gamma;
	gf_elem_t acc;
	gf_elem_t acc_nxt;
	logic [2:0] cyc;
	logic [2:0] cur_cyc;
	logic [1:0] k;
	logic [1:0] cur_k;
	logic [2:0] len;
	logic busy;
	logic swap;

	function automatic gf_elem_t syn_at(syn_vec_t s, int idx);
		case (idx)
			1: return s.s1;
			2: return s.s2;
			3: return s.s3;
			4: return s.s4;
			5: return s.s5;
			6: return s.s6;
			default: return '0;
		endcase
	endfunction

	// syn_done cycle is already the first discrepancy cycle
	assign cur_syn = syn_done ? syn : syn_q;
	assign cur_cyc = syn_done ? 3'd0 : cyc;
	assign cur_k = syn_done ? 2'd0 : k;

	always_comb begin
		for (int i = 0; i <= CODE_T; i++)
			cur_sig[i] = syn_done ? ((i == 0) ? ALPHA_POW[0] : '0) : sig[i];
	end

	// bit-serial sum of sigma_i * S(2k+1-i) with syndrome bits msb first
	always_comb begin
		int bit_sel;
		gf_elem_t syn_elem;
		bit_sel = FIELD_M - 1 - int'(cur_cyc);
		acc_nxt = gf_mul((cur_cyc == 3'd0) ? '0 : acc, ALPHA_POW[1]);
		for (int i = 0; i <= CODE_T; i++) begin
			syn_elem = syn_at(cur_syn, 2 * int'(cur_k) + 1 - i);
			if (syn_elem[bit_sel])
				acc_nxt = acc_nxt ^ cur_sig[i];
		end
	end

	assign swap = (acc != '0) && ({1'b0, k} >= len);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cyc <= '0;
			k <= '0;
			sigma_done <= 1'b0;
		end else begin
			sigma_done <= 1'b0;
			if (syn_done) begin
				busy <= 1'b1;
				cyc <= 3'd1;
				k <= '0;
			end else if (busy) begin
				if (cyc == 3'(BM_STEP_CYCLES - 1)) begin
					cyc <= '0;
					if (k == 2'(CODE_T - 1)) begin
						busy <= 1'b0;
						sigma_done <= 1'b1;
					end else begin
						k <= k + 2'd1;
					end
				end else begin
					cyc <= cyc + 3'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (syn_done) begin
			syn_q <= syn;
			acc <= acc_nxt;
			gamma <= ALPHA_POW[0];
			len <= '0;
			for (int i = 0; i <= CODE_T; i++) begin
				sig[i] <= (i == 0) ? ALPHA_POW[0] : '0;
				bb[i] <= (i == 0) ? ALPHA_POW[0] : '0;
			end
		end else if (busy) begin
			if (cyc < 3'(FIELD_M)) begin
				acc <= acc_nxt;
			end else if (cyc == 3'(FIELD_M)) begin
				// gamma*sigma + delta*x*B
				for (int i = 0; i <= CODE_T; i++)
					sig_nxt[i] <= gf_mul(gamma, sig[i]) ^
						((i > 0) ? gf_mul(acc, bb[i-1]) : '0);
			end else begin
				if (swap) begin
					gamma <= acc;
					len <= 3'd2 * {1'b0, k} + 3'd1 - len;
					for (int i = 0; i <= CODE_T; i++)
						bb[i] <= (i > 0) ? sig[i-1] : '0;
				end else begin
					// odd step skipped so B advances by x^2
					for (int i = 0; i <= CODE_T; i++)
						bb[i] <= (i > 1) ? bb[i-2] : '0;
				end
				for (int i = 0; i <= CODE_T; i++)
					sig[i] <= sig_nxt[i];
			end
		end
	end

	assign sigma.c0 = sig[0];
	assign sigma.c1 = sig[1];
	assign sigma.c2 = sig[2];
	assign sigma.c3 = sig[3];

endmodule

// ==== source/bch_chien.sv ====
`timescale 1ns/10ps

module bch_chien
	import bch_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   sigma_done,
	input  sigma_t sigma,
	output logic   err,
	output logic   search_done
);

	gf_elem_t coef [0:CODE_T];
	gf_elem_t term [0:CODE_T];
	gf_elem_t sum;
	logic [3:0] pos;
	logic active;

	// received bit 0 carries power 14, so its root test is x = alpha^1
	assign coef[0] = sigma.c0;
	assign coef[1] = sigma.c1;
	assign coef[2] = sigma.c2;
	assign coef[3] = sigma.c3;

	always_comb begin
		sum = '0;
		for (int i = 0; i <= CODE_T; i++)
			sum = sum ^ term[i];
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i <= CODE_T; i++) begin
			if (sigma_done)
				term[i] <= gf_mul(coef[i], ALPHA_POW[i]);
			else if (active)
				term[i] <= gf_mul(term[i], ALPHA_POW[i]);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active <= 1'b0;
			pos <= '0;
			err <= 1'b0;
			search_done <= 1'b0;
		end else begin
			search_done <= 1'b0;
			err <= active && (sum == '0);
			if (sigma_done) begin
				active <= 1'b1;
				pos <= '0;
			end else if (active) begin
				pos <= pos + 4'd1;
				if (pos == 4'(CODE_N - 1)) begin
					active <= 1'b0;
					search_done <= 1'b1;
				end
			end
		end
	end

endmodule

// ==== source/bch_decode.sv ====
`timescale 1ns/10ps

module bch_decode
	import bch_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  logic data_in,
	output logic ready,
	output logic output_valid,
	output logic data_out
);

	syn_vec_t syn;
	sigma_t sigma;
	logic syn_done;
	logic sigma_done;
	logic err;
	logic search_done;
	logic start_ok;
	logic sd_q;
	logic win;
	logic valid_q;
	logic err_q;
	logic [DECODE_LATENCY-2:0] dly;

	// a start while busy is ignored
	assign start_ok = start && ready;

	bch_syndrome bch_syndrome_inst (
		.clk(clk),
		.rst_n(rst_n),
		.start(start_ok),
		.data_in(data_in),
		.syn_done(syn_done),
		.syn(syn)
	);

	bch_berlekamp bch_berlekamp_inst (
		.clk(clk),
		.rst_n(rst_n),
		.syn_done(syn_done),
		.syn(syn),
		.sigma_done(sigma_done),
		.sigma(sigma)
	);

	bch_chien bch_chien_inst (
		.clk(clk),
		.rst_n(rst_n),
		.sigma_done(sigma_done),
		.sigma(sigma),
		.err(err),
		.search_done(search_done)
	);

	// next word may enter once the solver has released its syndromes
	always_ff @(posedge clk) begin
		if (!rst_n)
			ready <= 1'b1;
		else if (start_ok)
			ready <= 1'b0;
		else if (sigma_done)
			ready <= 1'b1;
	end

	// received bits, aligned with err_q
	always_ff @(posedge clk)
		dly <= {dly[DECODE_LATENCY-3:0], data_in};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sd_q <= 1'b0;
			win <= 1'b0;
			valid_q <= 1'b0;
			output_valid <= 1'b0;
		end else begin
			sd_q <= sigma_done;
			if (sd_q)
				win <= 1'b1;
			else if (search_done)
				win <= 1'b0;
			valid_q <= win;
			output_valid <= valid_q;
		end
	end

	always_ff @(posedge clk) begin
		err_q <= err && win;
		data_out <= (dly[DECODE_LATENCY-2] ^ err_q) && valid_q;
	end

endmodule

// ==== tb/bch_decode_checker.sv ====
`timescale 1ns/10ps

module bch_decode_checker
	import bch_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start,
	input  logic              ready,
	input  logic              output_valid,
	input  logic              data_out,
	input  logic [CODE_N-1:0] exp_word,
	output int                data_errors,
	output int                timing_errors,
	output int                pending
);

	localparam int EXPECT_LATENCY = 37;

	logic [CODE_N-1:0] exp_q [$];
	int start_q [$];
	logic [CODE_N-1:0] got;
	logic [CODE_N-1:0] want;
	int cycle;
	int burst_len;
	int word_idx;
	int latency;
	int start_cycle;
	int ready_due;
	logic ready_seen;
	logic ready_watch;
	logic in_reset;

	initial begin
		data_errors = 0;
		timing_errors = 0;
		pending = 0;
		cycle = 0;
		burst_len = 0;
		word_idx = 0;
		start_cycle = -2;
		ready_due = 0;
		ready_seen = 1'b0;
		ready_watch = 1'b0;
		in_reset = 1'b0;
		got = '0;
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			in_reset = 1'b1;
		end else begin
			// first cycle out of reset
			if (in_reset && (!ready || output_valid)) begin
				$display("[ERROR] %0t: after reset ready=%b output_valid=%b",
					$time, ready, output_valid);
				timing_errors++;
			end
			in_reset = 1'b0;
			if (ready)
				ready_seen = 1'b1;
			if (ready_watch && cycle == start_cycle + 1 && ready) begin
				$display("[ERROR] %0t: ready expected low after start got %b",
					$time, ready);
				timing_errors++;
			end
			// ready has to return before the word in flight comes out
			if (ready_watch && cycle == ready_due && !ready_seen) begin
				$display("[ERROR] %0t: ready expected high by output of word %0d got %b",
					$time, word_idx, ready);
				timing_errors++;
			end
			if (start && ready) begin
				exp_q.push_back(exp_word);
				start_q.push_back(cycle);
				start_cycle = cycle;
				ready_due = cycle + EXPECT_LATENCY;
				ready_seen = 1'b0;
				ready_watch = 1'b1;
			end
			if (output_valid) begin
				if (burst_len == 0 && start_q.size() != 0) begin
					latency = cycle - start_q.pop_front();
					if (latency != EXPECT_LATENCY) begin
						$display("[ERROR] %0t: word %0d latency expected %0d got %0d",
							$time, word_idx, EXPECT_LATENCY, latency);
						timing_errors++;
					end
				end
				// first bit out is the msb of the word
				got = {got[CODE_N-2:0], data_out};
				burst_len++;
				if (burst_len == CODE_N) begin
					if (exp_q.size() == 0) begin
						$display("output burst at %0t came with no word in flight", $time);
						data_errors++;
					end else begin
						want = exp_q.pop_front();
						if (got !== want) begin
							$display("[ERROR] %0t: word %0d expected %h got %h",
								$time, word_idx, want, got);
							data_errors++;
						end
						word_idx++;
					end
				end
			end else if (burst_len != 0) begin
				if (burst_len != CODE_N) begin
					$display("[ERROR] %0t: burst length expected %0d got %0d",
						$time, CODE_N, burst_len);
					timing_errors++;
				end
				burst_len = 0;
			end
			pending = exp_q.size();
		end
		cycle++;
	end

endmodule

// ==== tb/bch_decode_tb.sv ====
`timescale 1ns/10ps

module bch_decode_tb
	import bch_pkg::*;
();

	// x^10+x^8+x^5+x^4+x^2+x+1
	localparam logic [CODE_N-1:0] GEN_POLY = 15'h0537;
	localparam int READY_TIMEOUT = 2 * DECODE_LATENCY;
	localparam int DRAIN_TIMEOUT = 4 * DECODE_LATENCY;

	typedef struct packed {
		logic [CODE_K-1:0] msg;
		logic [CODE_N-1:0] mask;
		logic [3:0]        gap;
	} case_t;

	logic clk = 1'b0;
	logic rst_n;
	logic start;
	logic data_in;
	logic ready;
	logic output_valid;
	logic data_out;
	logic [CODE_N-1:0] exp_word;
	int data_errors;
	int timing_errors;
	int pending;
	int lost_words;
	int seed;
	logic timed_out;
	case_t cases [$];

	always #4 clk = ~clk;

	bch_decode bch_decode_inst (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.data_in(data_in),
		.ready(ready),
		.output_valid(output_valid),
		.data_out(data_out)
	);

	bch_decode_checker bch_decode_checker_inst (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.ready(ready),
		.output_valid(output_valid),
		.data_out(data_out),
		.exp_word(exp_word),
		.data_errors(data_errors),
		.timing_errors(timing_errors),
		.pending(pending)
	);

	// systematic: message in the top bits, remainder below
	function automatic logic [CODE_N-1:0] encode(input logic [CODE_K-1:0] msg);
		logic [CODE_N-1:0] rem;
		rem = {msg, {(CODE_N-CODE_K){1'b0}}};
		for (int i = CODE_N - 1; i >= CODE_N - CODE_K; i--) begin
			if (rem[i])
				rem = rem ^ (GEN_POLY << (i - (CODE_N - CODE_K)));
		end
		return {msg, rem[CODE_N-CODE_K-1:0]};
	endfunction

	task automatic add_case(input logic [CODE_K-1:0] msg, input logic [CODE_N-1:0] mask,
			input int gap);
		case_t c;
		c.msg = msg;
		c.mask = mask;
		c.gap = 4'(gap);
		cases.push_back(c);
	endtask

	task automatic build_table();
		logic [CODE_K-1:0] msg;
		logic [CODE_N-1:0] mask;
		int weight;
		int pos;
		for (int m = 0; m < 32; m++)
			add_case(5'(m), '0, 3);
		for (int p = 0; p < CODE_N; p++)
			add_case(5'(p * 7 + 3), 15'b1 << p, 2);
		// adjacent pairs and triples, both ends of the word
		add_case(5'h11, 15'h0003, 1);
		add_case(5'h0a, 15'h6000, 1);
		add_case(5'h1f, 15'h4001, 1);
		add_case(5'h05, 15'h0007, 1);
		add_case(5'h16, 15'h7000, 1);
		add_case(5'h09, 15'h4201, 1);
		add_case(5'h1c, 15'h0840, 1);
		add_case(5'h13, 15'h2a00, 1);
		for (int m = 0; m < 6; m++)
			add_case(5'(m * 5 + 1), 15'h0421 << m, 0);
		for (int n = 0; n < 24; n++) begin
			msg = 5'($random(seed));
			weight = int'($unsigned($random(seed)) % 32'd4);
			mask = '0;
			for (int w = 0; w < weight; w++) begin
				pos = int'($unsigned($random(seed)) % 32'd15);
				mask[pos] = 1'b1;
			end
			add_case(msg, mask, n % 3);
		end
	endtask

	task automatic wait_ready();
		int waited;
		waited = 0;
		while (!ready && !timed_out) begin
			if (waited >= READY_TIMEOUT) begin
				$display("timeout: ready stayed low for %0d cycles", waited);
				timed_out = 1'b1;
			end else begin
				@(posedge clk);
				#1;
				waited++;
			end
		end
	endtask

	task automatic send_word(input logic [CODE_N-1:0] clean, input logic [CODE_N-1:0] sent);
		wait_ready();
		if (!timed_out) begin
			exp_word = clean;
			start = 1'b1;
			data_in = sent[CODE_N-1];
			@(posedge clk);
			#1;
			start = 1'b0;
			for (int i = CODE_N - 2; i >= 0; i--) begin
				data_in = sent[i];
				@(posedge clk);
				#1;
			end
			data_in = 1'b0;
		end
	endtask

	task automatic drain_outputs();
		int waited;
		waited = 0;
		while (pending != 0 && waited < DRAIN_TIMEOUT) begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (pending != 0) begin
			$display("a decoded word was lost: %0d word(s) never came out", pending);
			lost_words = pending;
		end
	endtask

	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		data_in = 1'b0;
		exp_word = '0;
		lost_words = 0;
		timed_out = 1'b0;
		seed = 32'he41c_d42d;
		build_table();
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		foreach (cases[i]) begin
			if (!timed_out) begin
				send_word(encode(cases[i].msg), encode(cases[i].msg) ^ cases[i].mask);
				repeat (cases[i].gap) begin
					@(posedge clk);
					#1;
				end
			end
		end
		if (!timed_out)
			drain_outputs();
		repeat (4) @(posedge clk);
		$display("counts: %0d data errors, %0d timing errors, %0d lost words, timeout %0d",
			data_errors, timing_errors, lost_words, timed_out);
		if (data_errors + timing_errors + lost_words == 0 && !timed_out)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== vlog.f ====
source/bch_pkg.sv
source/bch_syndrome.sv
source/bch_berlekamp.sv
source/bch_chien.sv
source/bch_decode.sv
tb/bch_decode_checker.sv
tb/bch_decode_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= bch_decode_tb
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing
FAIL_MSG ?= Finished with errors
PASS_MSG ?= Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no result found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
